// ==== Makefile ====
# Verilator simulation of the POV display core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run tb_pov, pass only if sim.log has the pass message"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_pov \
		-Mdir obj_dir -o tb_pov
	./obj_dir/tb_pov | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== cmd_decoder.sv ====
//--------------------
// Four-byte command decoder
// Pixel writes, enable, period read-back
//--------------------
`include "pov_params.svh"

module cmd_decoder (
  input logic clk,
  input logic nrst,
  spi_byte_if.dec spi,
  fb_wr_if.src fb,
  input logic [`POV_PER_W-1:0] period
);

  import pov_pkg::*;

  dec_state_t             state;
  pov_opcode_t            opcode;
  logic [7:0]             arg1;
  logic [7:0]             arg2;
  // Snapshot so all three bytes come from one value
  logic [`POV_PER_W-1:0]  per_latch;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      state       <= DEC_OPCODE;
      opcode      <= OP_NOP;
      fb.wr_en    <= 1'b0;
      fb.en_set   <= 1'b0;
      spi.tx_byte <= '0;
    end else begin
      fb.wr_en  <= 1'b0;
      fb.en_set <= 1'b0;
      if (spi.frame_start) begin
        // Short frames are dropped here
        state       <= DEC_OPCODE;
        spi.tx_byte <= '0;
      end else if (spi.rx_valid) begin
        case (state)
          DEC_OPCODE: begin
            if (spi.byte_idx == 2'd0) begin
              opcode <= pov_opcode_t'(spi.rx_byte);
              state  <= DEC_ARGS;
              // MSB of period goes out during byte 1
              if (pov_opcode_t'(spi.rx_byte) == OP_RD_PER) begin
                spi.tx_byte <= period[`POV_PER_W-1 -: 8];
              end
            end
          end
          DEC_ARGS: begin
            case (spi.byte_idx)
              2'd1: begin
                if (opcode == OP_RD_PER) begin
                  spi.tx_byte <= per_latch[`POV_PER_W-9 -: 8];
                end
              end
              2'd2: begin
                if (opcode == OP_RD_PER) begin
                  spi.tx_byte <= per_latch[`POV_PER_W-17 -: 8];
                end
              end
              default: begin
                spi.tx_byte <= '0;
              end
            endcase
            // Last byte, run the command
            if (spi.byte_idx == 2'd3) begin
              state <= DEC_OPCODE;
              case (opcode)
                OP_WR_PIX: fb.wr_en  <= 1'b1;
                OP_ENABLE: fb.en_set <= 1'b1;
                default: ;
              endcase
            end
          end
          default: state <= DEC_OPCODE;
        endcase
      end
    end
  end

  // Argument and write payload capture
  always_ff @(posedge clk) begin
    if (spi.rx_valid) begin
      case (spi.byte_idx)
        2'd0: per_latch <= period;
        2'd1: arg1 <= spi.rx_byte;
        2'd2: arg2 <= spi.rx_byte;
        default: begin
          fb.wr_slice <= arg1[`POV_SLICE_BITS-1:0];
          fb.wr_led   <= arg2[`POV_LED_BITS-1:0];
          fb.wr_pixel <= spi.rx_byte[`POV_PIX_W-1:0];
          fb.en_level <= arg1[0];
        end
      endcase
    end
  end

  // Every frame starts over in the opcode state
  assert property (@(posedge clk) disable iff (!nrst)
    (spi.rx_valid && state == DEC_ARGS) |-> spi.byte_idx != 2'd0);

endmodule

// ==== column_shifter.sv ====
//--------------------
// Serial column output to LED drivers
// sclk, sin and latch pulse per slice
//--------------------
`include "pov_params.svh"

module column_shifter (
  input  logic            clk,
  input  logic            nrst,
  input  logic            slice_strobe,
  input  pov_pkg::slice_t slice_idx,
  fb_rd_if.reader         rd,
  output logic            sclk,
  output logic            sin,
  output logic            lat
);

  import pov_pkg::*;

  // Two sclk phases per pixel bit
  localparam int unsigned PH_W = $clog2(2 * `POV_PIX_W);
  localparam logic [PH_W-1:0] PH_LAST = PH_W'(2 * `POV_PIX_W - 1);
  localparam led_t LED_LAST = led_t'(`POV_LEDS - 1);

  shift_state_t          state;
  led_t                  led;
  slice_t                cur_slice;
  logic [PH_W-1:0]       phase;
  logic [`POV_PIX_W-1:0] pix_sh;

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      state <= SH_IDLE;
      led   <= '0;
      phase <= '0;
    end else begin
      case (state)
        SH_IDLE: begin
          // Strobes during a column are ignored
          if (slice_strobe) begin
            led   <= '0;
            state <= SH_READ;
          end
        end
        SH_READ: begin
          phase <= '0;
          state <= SH_SHIFT;
        end
        SH_SHIFT: begin
          if (phase == PH_LAST) begin
            if (led == LED_LAST) begin
              state <= SH_LATCH;
            end else begin
              led   <= led + 1'b1;
              state <= SH_READ;
            end
          end else begin
            phase <= phase + 1'b1;
          end
        end
        SH_LATCH: state <= SH_IDLE;
        default: state <= SH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == SH_IDLE && slice_strobe) begin
      cur_slice <= slice_idx;
    end
  end

  // One pixel read per LED, rd_data holds through the shift
  assign rd.rd_en    = (state == SH_READ);
  assign rd.rd_slice = cur_slice;
  assign rd.rd_led   = led;

  // MSB first, bit index is phase without its low bit
  assign pix_sh = rd.rd_data << phase[PH_W-1:1];

  // Low half then high half of each bit
  assign sclk = (state == SH_SHIFT) & phase[0];
  assign sin  = (state == SH_SHIFT) & pix_sh[`POV_PIX_W-1];
  assign lat  = (state == SH_LATCH);

  // Latch always directly follows the last bit of a column
  assert property (@(posedge clk) disable iff (!nrst)
    lat |-> $past(state == SH_SHIFT && phase == PH_LAST && led == LED_LAST));

endmodule

// ==== frame_store.sv ====
//--------------------
// Pixel RAM, one write and one read port
// Display enable register
//--------------------
`include "pov_params.svh"

module frame_store (
  input logic clk,
  input logic nrst,
  fb_wr_if.store wr,
  fb_rd_if.store rd
);

  localparam int unsigned DEPTH = `POV_SLICES * `POV_LEDS;

  // Addressed by {slice, led}
  logic [`POV_PIX_W-1:0] mem [DEPTH];
  logic                  enable;

  // Registered read, blanked while the display is off
  always_ff @(posedge clk) begin
    if (wr.wr_en) begin
      mem[{wr.wr_slice, wr.wr_led}] <= wr.wr_pixel;
    end
    if (rd.rd_en) begin
      rd.rd_data <= enable ? mem[{rd.rd_slice, rd.rd_led}] : '0;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      enable <= 1'b0;
    end else if (wr.en_set) begin
      enable <= wr.en_level;
    end
  end

endmodule

// ==== pov_ifs.sv ====
//--------------------
// spi_byte_if: SPI bytes to decoder
// fb_wr_if: framebuffer writes, enable
// fb_rd_if: framebuffer column reads
//--------------------
`include "pov_params.svh"

interface spi_byte_if;
  // Byte strobe with frame position
  logic       rx_valid;
  logic [7:0] rx_byte;
  logic [1:0] byte_idx;
  logic       frame_start;
  // Next byte for MISO
  logic [7:0] tx_byte;

  modport phy (output rx_valid, rx_byte, byte_idx, frame_start, input tx_byte);
  modport dec (input rx_valid, rx_byte, byte_idx, frame_start, output tx_byte);
endinterface

interface fb_wr_if;
  import pov_pkg::*;

  logic                  wr_en;
  slice_t                wr_slice;
  led_t                  wr_led;
  logic [`POV_PIX_W-1:0] wr_pixel;
  // Display enable, taken on en_set
  logic                  en_level;
  logic                  en_set;

  modport src (output wr_en, wr_slice, wr_led, wr_pixel, en_level, en_set);
  modport store (input wr_en, wr_slice, wr_led, wr_pixel, en_level, en_set);
endinterface

interface fb_rd_if;
  import pov_pkg::*;

  logic                  rd_en;
  slice_t                rd_slice;
  led_t                  rd_led;
  // Valid one cycle after rd_en, held until the next read
  logic [`POV_PIX_W-1:0] rd_data;

  modport reader (output rd_en, rd_slice, rd_led, input rd_data);
  modport store (input rd_en, rd_slice, rd_led, output rd_data);
endinterface

// ==== pov_params.svh ====
//--------------------
// Display geometry and counter widths
// Slice count must stay a power of two
//--------------------
`ifndef POV_PARAMS_SVH
`define POV_PARAMS_SVH

// Slices per turn and its log2
`define POV_SLICES 8
`define POV_SLICE_BITS 3

// LEDs per column and index width
`define POV_LEDS 16
`define POV_LED_BITS 4

// Bits per pixel
`define POV_PIX_W 8

// Turn period counter, saturating
`define POV_PER_W 24

`endif

// ==== pov_pkg.sv ====
//--------------------
// Shared types of the display core
// Opcodes, FSM states, index types
//--------------------
`include "pov_params.svh"

package pov_pkg;

  // Host command opcodes, anything else is a NOP
  typedef enum logic [7:0] {
    OP_NOP    = 8'h00,
    OP_WR_PIX = 8'h01,
    OP_ENABLE = 8'h02,
    OP_RD_PER = 8'h03
  } pov_opcode_t;

  // Framebuffer indices
  typedef logic [`POV_SLICE_BITS-1:0] slice_t;
  typedef logic [`POV_LED_BITS-1:0] led_t;

  // Column shifter FSM
  typedef enum logic [1:0] {
    SH_IDLE,
    SH_READ,
    SH_SHIFT,
    SH_LATCH
  } shift_state_t;

  // Command decoder FSM
  typedef enum logic {
    DEC_OPCODE,
    DEC_ARGS
  } dec_state_t;

endpackage

// ==== pov_top.sv ====
//--------------------
// Display core top level
// SPI link, framebuffer, timing, driver output
//--------------------
`include "pov_params.svh"

module pov_top (
  input  logic clk,
  input  logic nrst,
  input  logic spi_sclk,
  input  logic spi_cs,
  input  logic spi_mosi,
  input  logic hall,
  output logic spi_miso,
  output logic drv_sclk,
  output logic drv_sin,
  output logic drv_lat
);

  import pov_pkg::*;

  spi_byte_if spi_bus ();
  fb_wr_if    fb_wr ();
  fb_rd_if    fb_rd ();

  logic [`POV_PER_W-1:0] period;
  logic                  slice_strobe;
  slice_t                slice_idx;

  // Host command path
  spi_rx spi_rx0 (
    .clk  (clk),
    .nrst (nrst),
    .sclk (spi_sclk),
    .cs   (spi_cs),
    .mosi (spi_mosi),
    .miso (spi_miso),
    .bus  (spi_bus.phy)
  );

  cmd_decoder cmd_decoder0 (
    .clk    (clk),
    .nrst   (nrst),
    .spi    (spi_bus.dec),
    .fb     (fb_wr.src),
    .period (period)
  );

  frame_store frame_store0 (
    .clk  (clk),
    .nrst (nrst),
    .wr   (fb_wr.store),
    .rd   (fb_rd.store)
  );

  // Rotation timing and column output
  slice_timer slice_timer0 (
    .clk          (clk),
    .nrst         (nrst),
    .hall         (hall),
    .period       (period),
    .slice_strobe (slice_strobe),
    .slice_idx    (slice_idx)
  );

  column_shifter column_shifter0 (
    .clk          (clk),
    .nrst         (nrst),
    .slice_strobe (slice_strobe),
    .slice_idx    (slice_idx),
    .rd           (fb_rd.reader),
    .sclk         (drv_sclk),
    .sin          (drv_sin),
    .lat          (drv_lat)
  );

endmodule

// ==== sim.f ====
+incdir+.
pov_pkg.sv
pov_ifs.sv
spi_rx.sv
cmd_decoder.sv
frame_store.sv
slice_timer.sv
column_shifter.sv
pov_top.sv
tb_pov.sv

// ==== slice_timer.sv ====
//--------------------
// Hall sync and turn period measurement
// Slice strobe generation
//--------------------
`include "pov_params.svh"

module slice_timer (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  hall,
  output logic [`POV_PER_W-1:0] period,
  output logic                  slice_strobe,
  output pov_pkg::slice_t       slice_idx
);

  import pov_pkg::*;

  localparam logic [`POV_PER_W-1:0] CNT_MAX = '1;
  localparam slice_t LAST_BUT_ONE = slice_t'(`POV_SLICES - 2);

  // [0] meta, [1] sync, [2] previous sync
  logic [2:0]            hall_sr;
  logic                  hall_fall;
  logic [`POV_PER_W-1:0] turn_cnt;
  logic [`POV_PER_W-1:0] slice_len;
  logic [`POV_PER_W-1:0] slice_cnt;
  logic                  seen_edge;
  logic                  running;

  // Sensor idles high, falling edge marks start of turn
  assign hall_fall = hall_sr[2] & ~hall_sr[1];

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      hall_sr      <= '1;
      turn_cnt     <= '0;
      period       <= '0;
      slice_len    <= '0;
      slice_cnt    <= '0;
      seen_edge    <= 1'b0;
      running      <= 1'b0;
      slice_strobe <= 1'b0;
      slice_idx    <= '0;
    end else begin
      hall_sr      <= {hall_sr[1:0], hall};
      slice_strobe <= 1'b0;
      if (hall_fall) begin
        // Cycle after the edge counts as 1
        turn_cnt  <= `POV_PER_W'(1);
        period    <= turn_cnt;
        slice_len <= turn_cnt >> `POV_SLICE_BITS;
        slice_cnt <= `POV_PER_W'(1);
        seen_edge <= 1'b1;
        // Period only valid from the second edge on
        if (seen_edge) begin
          running      <= 1'b1;
          slice_strobe <= 1'b1;
          slice_idx    <= '0;
        end
      end else begin
        if (turn_cnt != CNT_MAX) begin
          turn_cnt <= turn_cnt + 1'b1;
        end
        if (running) begin
          if (slice_cnt == slice_len) begin
            slice_cnt    <= `POV_PER_W'(1);
            slice_strobe <= 1'b1;
            slice_idx    <= slice_idx + 1'b1;
            // Stop once the last slice of the turn is out
            if (slice_idx == LAST_BUT_ONE) begin
              running <= 1'b0;
            end
          end else begin
            slice_cnt <= slice_cnt + 1'b1;
          end
        end
      end
    end
  end

  // Slice 0 only right after a hall edge, the index never wraps
  assert property (@(posedge clk) disable iff (!nrst)
    (slice_strobe && slice_idx == '0) |-> $past(hall_fall));

endmodule

// ==== spi_rx.sv ====
//--------------------
// SPI slave, mode 0, MSB first
// Byte assembly and MISO shifting
//--------------------
module spi_rx (
  input  logic clk,
  input  logic nrst,
  input  logic sclk,
  input  logic cs,
  input  logic mosi,
  output logic miso,
  spi_byte_if.phy bus
);

  // [0] meta, [1] sync, [2] previous sync
  logic [2:0] sclk_sr;
  logic [2:0] cs_sr;
  // mosi delayed to line up with sclk_sr[1]
  logic [1:0] mosi_sr;

  logic       sclk_rise;
  logic       sclk_fall;
  logic       cs_fall;
  logic       cs_low;

  logic [2:0] bit_cnt;
  logic [1:0] byte_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;

  assign sclk_rise = sclk_sr[1] & ~sclk_sr[2];
  assign sclk_fall = ~sclk_sr[1] & sclk_sr[2];
  assign cs_fall   = ~cs_sr[1] & cs_sr[2];
  assign cs_low    = ~cs_sr[1];

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      sclk_sr <= '0;
      cs_sr   <= '1;
      mosi_sr <= '0;
    end else begin
      sclk_sr <= {sclk_sr[1:0], sclk};
      cs_sr   <= {cs_sr[1:0], cs};
      mosi_sr <= {mosi_sr[0], mosi};
    end
  end

  // Bit and byte counters, restart on every frame
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      bit_cnt         <= '0;
      byte_cnt        <= '0;
      bus.rx_valid    <= 1'b0;
      bus.frame_start <= 1'b0;
    end else begin
      bus.rx_valid    <= 1'b0;
      bus.frame_start <= cs_fall;
      if (cs_fall) begin
        bit_cnt  <= '0;
        byte_cnt <= '0;
      end else if (cs_low && sclk_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        // Eighth bit completes the byte
        if (bit_cnt == 3'd7) begin
          bus.rx_valid <= 1'b1;
          byte_cnt     <= byte_cnt + 2'd1;
        end
      end
    end
  end

  // Receive data path
  always_ff @(posedge clk) begin
    if (cs_low && sclk_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_sr[1]};
      if (bit_cnt == 3'd7) begin
        bus.rx_byte  <= {rx_shift[6:0], mosi_sr[1]};
        bus.byte_idx <= byte_cnt;
      end
    end
  end

  // Transmit, new byte loaded at frame start and after each full byte
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      tx_shift <= bus.tx_byte;
    end else if (cs_low && sclk_fall) begin
      tx_shift <= (bit_cnt == 3'd0) ? bus.tx_byte : {tx_shift[6:0], 1'b0};
    end
  end

  assign miso = cs_low & tx_shift[7];

  // Bytes are only reported from inside a frame
  assert property (@(posedge clk) disable iff (!nrst) bus.rx_valid |-> !cs);

endmodule

// ==== tb_pov.sv ====
//--------------------
// Testbench for pov_top
// SPI host, hall sensor, column capture
// Framebuffer model and checks
//--------------------
`include "pov_params.svh"

module tb_pov;

  import pov_pkg::*;

  localparam int COL_W = `POV_LEDS * `POV_PIX_W;
  // Hall spacing in clk cycles
  localparam int TURN = 3200;

  logic clk;
  logic nrst;
  logic spi_sclk;
  logic spi_cs;
  logic spi_mosi;
  logic hall;
  logic spi_miso;
  logic drv_sclk;
  logic drv_sin;
  logic drv_lat;

  // Model of the framebuffer
  logic [`POV_PIX_W-1:0] fb_model [`POV_SLICES][`POV_LEDS];
  logic                  fb_valid [`POV_SLICES][`POV_LEDS];
  logic                  model_en;

  int          errors;
  int          checked_on;
  int          skipped;
  int          cycle;
  int          hall_edges;
  int          lat_in_turn;
  logic        aborted;
  logic        cmd_active;
  int          dirty_end;
  logic [31:0] rng;

  // Capture state
  logic [COL_W-1:0] col;
  int               nbits;
  int               col_start;
  logic             prev_sclk;

  pov_top dut0 (
    .clk      (clk),
    .nrst     (nrst),
    .spi_sclk (spi_sclk),
    .spi_cs   (spi_cs),
    .spi_mosi (spi_mosi),
    .hall     (hall),
    .spi_miso (spi_miso),
    .drv_sclk (drv_sclk),
    .drv_sin  (drv_sin),
    .drv_lat  (drv_lat)
  );

  always #10 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic check_val(input string name, input logic [COL_W-1:0] exp,
                           input logic [COL_W-1:0] act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected column, LED 0 first, MSB first
  function automatic logic [COL_W-1:0] ref_column(input int s);
    logic [COL_W-1:0] c;
    c = '0;
    for (int l = 0; l < `POV_LEDS; l++) begin
      c = (c << `POV_PIX_W) | COL_W'(model_en ? fb_model[s][l] : '0);
    end
    return c;
  endfunction

  // Unwritten RAM words are unknown, so only written pixels count
  function automatic logic [COL_W-1:0] col_mask(input int s);
    logic [COL_W-1:0] m;
    m = '0;
    for (int l = 0; l < `POV_LEDS; l++) begin
      m = (m << `POV_PIX_W) | COL_W'({`POV_PIX_W{!model_en || fb_valid[s][l]}});
    end
    return m;
  endfunction

  // Mode 0 frame at clk/16, returns what came back on MISO
  task automatic send_frame(input logic [31:0] word, output logic [31:0] rx);
    rx = '0;
    if (!aborted) begin
      cmd_active = 1'b1;
      @(posedge clk);
      #2 spi_cs = 1'b0;
      repeat (8) @(posedge clk);
      for (int i = 31; i >= 0; i--) begin
        #2 spi_sclk = 1'b0;
        spi_mosi = word[i];
        repeat (8) @(posedge clk);
        // Host samples MISO as it raises sclk
        #2 rx = {rx[30:0], spi_miso};
        spi_sclk = 1'b1;
        repeat (8) @(posedge clk);
      end
      #2 spi_sclk = 1'b0;
      repeat (8) @(posedge clk);
      #2 spi_cs = 1'b1;
      spi_mosi = 1'b0;
      repeat (8) @(posedge clk);
      // Columns shifted up to here may mix old and new contents
      dirty_end = cycle + 8;
      cmd_active = 1'b0;
    end
  endtask

  task automatic write_pixel(input int s, input int l, input logic [7:0] p);
    logic [31:0] rx;
    send_frame({OP_WR_PIX, 8'(s), 8'(l), p}, rx);
    fb_model[s][l] = p;
    fb_valid[s][l] = 1'b1;
  endtask

  // Slices in turn, LED and pixel from the generator
  task automatic random_writes(input int n);
    for (int i = 0; i < n; i++) begin
      rng = xorshift32(rng);
      write_pixel(i % `POV_SLICES, int'(rng[`POV_LED_BITS-1:0]), rng[15:8] | 8'h01);
    end
  endtask

  task automatic set_enable(input logic en);
    logic [31:0] rx;
    send_frame({OP_ENABLE, 7'd0, en, 16'h0000}, rx);
    model_en = en;
  endtask

  task automatic read_period();
    logic [31:0] rx;
    send_frame({OP_RD_PER, 24'h000000}, rx);
    // Byte 0 carries nothing, period follows MSB first
    if (!aborted) begin
      check_val("period readback", COL_W'(TURN), COL_W'(rx[23:0]));
    end
  endtask

  // Bounded wait for n further hall edges
  task automatic wait_turns(input int n);
    int target;
    int cnt;
    target = hall_edges + n;
    cnt = 0;
    while (!aborted && hall_edges < target) begin
      @(posedge clk);
      cnt++;
      if (cnt > (n + 1) * TURN) begin
        $display("Timeout: hall edge %0d never came", target);
        errors++;
        aborted = 1'b1;
      end
    end
  endtask

  // Hall pulses low for 4 cycles once per turn
  initial begin
    hall = 1'b1;
    repeat (10) @(posedge clk);
    forever begin
      #2;
      // Latch count of the turn that just ended
      check_val($sformatf("latches in turn %0d", hall_edges),
                COL_W'(hall_edges >= 2 ? `POV_SLICES : 0), COL_W'(lat_in_turn));
      lat_in_turn = 0;
      hall_edges++;
      hall = 1'b0;
      repeat (4) @(posedge clk);
      #2 hall = 1'b1;
      repeat (TURN - 4) @(posedge clk);
    end
  end

  // Column capture, sampled mid-cycle where outputs are settled
  always @(negedge clk) begin
    if (nrst) begin
      if (hall_edges < 2) begin
        check_val("idle outputs", '0, COL_W'({drv_sclk, drv_sin, drv_lat, spi_miso}));
      end
      if (drv_sclk && !prev_sclk) begin
        if (nbits == 0) begin
          col_start = cycle;
        end
        col = {col[COL_W-2:0], drv_sin};
        nbits++;
      end
      if (drv_lat) begin
        check_val("bits per column", COL_W'(COL_W), COL_W'(nbits));
        if (lat_in_turn >= `POV_SLICES) begin
          $display("Too many latch pulses after hall edge %0d", hall_edges);
          errors++;
        end else if (cmd_active || dirty_end >= col_start) begin
          skipped++;
        end else begin
          // Slice number follows from the latch order in the turn
          check_val($sformatf("column of slice %0d", lat_in_turn),
                    ref_column(lat_in_turn), col & col_mask(lat_in_turn));
          if (model_en) begin
            checked_on++;
          end
        end
        lat_in_turn++;
        nbits = 0;
        col = '0;
      end
      prev_sclk = drv_sclk;
    end
  end

  initial begin
    clk        = 1'b0;
    nrst       = 1'b0;
    spi_sclk   = 1'b0;
    spi_cs     = 1'b1;
    spi_mosi   = 1'b0;
    model_en   = 1'b0;
    errors     = 0;
    checked_on = 0;
    skipped    = 0;
    cycle      = 0;
    hall_edges = 0;
    lat_in_turn = 0;
    aborted    = 1'b0;
    cmd_active = 1'b0;
    dirty_end  = -1;
    rng        = 32'h6387_e46b;
    col        = '0;
    nbits      = 0;
    col_start  = 0;
    prev_sclk  = 1'b0;
    for (int s = 0; s < `POV_SLICES; s++) begin
      for (int l = 0; l < `POV_LEDS; l++) begin
        fb_model[s][l] = '0;
        fb_valid[s][l] = 1'b0;
      end
    end

    repeat (4) @(posedge clk);
    #2 nrst = 1'b1;

    // Quiet until two hall edges have passed
    wait_turns(2);
    // Display off, writes stay invisible
    random_writes(16);
    wait_turns(2);
    set_enable(1'b1);
    random_writes(16);
    wait_turns(2);
    read_period();
    // Off and on again, contents must survive
    set_enable(1'b0);
    wait_turns(2);
    set_enable(1'b1);
    wait_turns(2);

    if (checked_on == 0) begin
      $display("No column was compared while the display was enabled");
      errors++;
    end
    $display("Done: %0d errors, %0d enabled columns checked, %0d columns skipped",
             errors, checked_on, skipped);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
